//--- verilog/cache_types_pkg.sv
package cache_types_pkg;

    // cache geometry
    localparam int NUM_BANKS     = 2;
    localparam int NUM_WAYS      = 4;    // tree lru assumes four
    localparam int SETS_PER_BANK = 4;
    localparam int BLOCK_WORDS   = 4;

    // byte address field positions
    localparam int WORD_OFF_LSB = 2;
    localparam int BANK_LSB     = WORD_OFF_LSB + $clog2(BLOCK_WORDS);
    localparam int SET_LSB      = BANK_LSB + $clog2(NUM_BANKS);
    localparam int TAG_LSB      = SET_LSB + $clog2(SETS_PER_BANK);

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  uuid_t;

    typedef logic [31-TAG_LSB:0]                tag_t;
    typedef logic [$clog2(SETS_PER_BANK)-1:0]   set_idx_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]        way_t;
    typedef logic [$clog2(BLOCK_WORDS)-1:0]     word_off_t;

    // [2] half used last, [0] way 0/1 used last, [1] way 2/3 used last
    typedef logic [2:0] lru_t;

    typedef enum logic [2:0] {
        IDLE,
        VICTIM_EJECT,
        BLOCK_PULL,
        INSTALL,
        REPLY
    } bank_state_t;

endpackage

//--- verilog/bank_dispatch.sv
`timescale 1ns/10ps

module bank_dispatch (
    input  logic                                   CLK,
    input  logic                                   nRST,
    input  logic                                   req_valid,
    input  logic                                   req_write,
    input  cache_types_pkg::addr_t                 req_addr,
    input  cache_types_pkg::word_t                 req_wdata,
    input  cache_types_pkg::uuid_t                 req_uuid,
    input  logic [cache_types_pkg::NUM_BANKS-1:0]  busy,
    output logic                                   req_ready,
    output logic [cache_types_pkg::NUM_BANKS-1:0]  bank_req_valid,
    output logic                                   bank_write,
    output cache_types_pkg::addr_t                 bank_addr,
    output cache_types_pkg::word_t                 bank_wdata,
    output cache_types_pkg::uuid_t                 bank_uuid
);
    import cache_types_pkg::*;

    logic                          slot_valid;
    logic                          slot_write;
    addr_t                         slot_addr;
    word_t                         slot_wdata;
    uuid_t                         slot_uuid;
    logic [$clog2(NUM_BANKS)-1:0]  slot_bank;
    logic                          bank_free;
    logic                          issue;
    logic                          accept;

    assign slot_bank = slot_addr[BANK_LSB +: $clog2(NUM_BANKS)];
    assign bank_free = !busy[slot_bank];
    assign issue     = slot_valid && bank_free;

    // slot can refill on the same edge it drains
    assign req_ready = !slot_valid || bank_free;
    assign accept    = req_valid && req_ready;

    assign bank_req_valid = {NUM_BANKS{issue}} & (NUM_BANKS'(1) << slot_bank);
    assign bank_write     = slot_write;
    assign bank_addr      = slot_addr;
    assign bank_wdata     = slot_wdata;
    assign bank_uuid      = slot_uuid;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            slot_valid <= 1'b0;
        end else if (accept) begin
            slot_valid <= 1'b1;
        end else if (issue) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            slot_write <= req_write;
            slot_addr  <= req_addr;
            slot_wdata <= req_wdata;
            slot_uuid  <= req_uuid;
        end
    end

endmodule

//--- verilog/cache_bank.sv
`timescale 1ns/10ps

module cache_bank (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    req_valid,
    input  logic                    req_write,
    input  cache_types_pkg::addr_t  req_addr,
    input  cache_types_pkg::word_t  req_wdata,
    input  cache_types_pkg::uuid_t  req_uuid,
    input  logic                    mem_ack,
    input  cache_types_pkg::word_t  mem_rdata,
    output logic                    busy,
    output logic                    resp_valid,
    output cache_types_pkg::word_t  resp_data,
    output cache_types_pkg::uuid_t  resp_uuid,
    output logic                    mem_req,
    output logic                    mem_we,
    output cache_types_pkg::addr_t  mem_addr,
    output cache_types_pkg::word_t  mem_wdata
);
    import cache_types_pkg::*;

    logic [SETS_PER_BANK-1:0][NUM_WAYS-1:0] valid_arr;
    logic [SETS_PER_BANK-1:0][NUM_WAYS-1:0] dirty_arr;
    lru_t [SETS_PER_BANK-1:0]               lru_arr;
    tag_t                                   tag_arr  [SETS_PER_BANK][NUM_WAYS];
    word_t                                  data_arr [SETS_PER_BANK][NUM_WAYS][BLOCK_WORDS];
    word_t                                  block_buf [BLOCK_WORDS];

    bank_state_t state;
    word_off_t   cnt;
    logic        last_word;

    set_idx_t  req_set;
    tag_t      req_tag;
    word_off_t req_off;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    logic      victim_dirty;
    logic      take_hit;
    logic      take_miss;

    // latched miss
    logic      m_write;
    addr_t     m_addr;
    word_t     m_wdata;
    uuid_t     m_uuid;
    way_t      m_way;
    set_idx_t  m_set;
    tag_t      m_tag;
    word_off_t m_off;

    function automatic lru_t lru_touch(lru_t cur, way_t w);
        lru_t nxt;
        nxt    = cur;
        nxt[2] = w[1];
        if (w[1]) nxt[1] = w[0];
        else      nxt[0] = w[0];
        return nxt;
    endfunction

    // point away from the last used half and way
    function automatic way_t lru_victim(lru_t cur);
        way_t v;
        if (cur[2]) v = {1'b0, ~cur[0]};
        else        v = {1'b1, ~cur[1]};
        return v;
    endfunction

    assign req_set = req_addr[SET_LSB +: $bits(set_idx_t)];
    assign req_tag = req_addr[TAG_LSB +: $bits(tag_t)];
    assign req_off = req_addr[WORD_OFF_LSB +: $bits(word_off_t)];

    assign m_set = m_addr[SET_LSB +: $bits(set_idx_t)];
    assign m_tag = m_addr[TAG_LSB +: $bits(tag_t)];
    assign m_off = m_addr[WORD_OFF_LSB +: $bits(word_off_t)];

    assign busy      = (state != IDLE);
    assign last_word = (cnt == word_off_t'(BLOCK_WORDS - 1));
    assign take_hit  = req_valid && !busy && hit;
    assign take_miss = req_valid && !busy && !hit;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (valid_arr[req_set][w] && (tag_arr[req_set][w] == req_tag)) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    always_comb begin
        logic has_free;
        way_t free_way;
        has_free = 1'b0;
        free_way = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin // lowest empty way wins
            if (!valid_arr[req_set][w]) begin
                has_free = 1'b1;
                free_way = way_t'(w);
            end
        end
        victim_way   = has_free ? free_way : lru_victim(lru_arr[req_set]);
        victim_dirty = valid_arr[req_set][victim_way] && dirty_arr[req_set][victim_way];
    end

    always_comb begin
        mem_req   = (state == VICTIM_EJECT) || (state == BLOCK_PULL);
        mem_we    = (state == VICTIM_EJECT);
        mem_wdata = data_arr[m_set][m_way][cnt];
        if (mem_we) begin // victim shares set and bank bits with the miss
            mem_addr = {tag_arr[m_set][m_way], m_addr[TAG_LSB-1:BANK_LSB], cnt,
                        {WORD_OFF_LSB{1'b0}}};
        end else begin
            mem_addr = {m_addr[31:BANK_LSB], cnt, {WORD_OFF_LSB{1'b0}}};
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state      <= IDLE;
            cnt        <= '0;
            valid_arr  <= '0;
            dirty_arr  <= '0;
            lru_arr    <= '0;
            resp_valid <= 1'b0;
        end else begin
            resp_valid <= take_hit || (state == INSTALL);
            case (state)
                IDLE: begin
                    cnt <= '0;
                    if (take_hit) begin
                        lru_arr[req_set] <= lru_touch(lru_arr[req_set], hit_way);
                        if (req_write) dirty_arr[req_set][hit_way] <= 1'b1;
                    end else if (take_miss) begin
                        state <= victim_dirty ? VICTIM_EJECT : BLOCK_PULL;
                    end
                end
                VICTIM_EJECT: begin
                    if (mem_ack) begin
                        cnt <= cnt + 1'b1;
                        if (last_word) state <= BLOCK_PULL;
                    end
                end
                BLOCK_PULL: begin
                    if (mem_ack) begin
                        cnt <= cnt + 1'b1;
                        if (last_word) state <= INSTALL;
                    end
                end
                INSTALL: begin
                    valid_arr[m_set][m_way] <= 1'b1;
                    dirty_arr[m_set][m_way] <= m_write; // merged write word is not in memory
                    lru_arr[m_set]          <= lru_touch(lru_arr[m_set], m_way);
                    state                   <= REPLY;
                end
                REPLY:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (take_hit) begin
            if (req_write) data_arr[req_set][hit_way][req_off] <= req_wdata;
            resp_data <= req_write ? req_wdata : data_arr[req_set][hit_way][req_off];
            resp_uuid <= req_uuid;
        end
        if (take_miss) begin
            m_write <= req_write;
            m_addr  <= req_addr;
            m_wdata <= req_wdata;
            m_uuid  <= req_uuid;
            m_way   <= victim_way;
        end
        if ((state == BLOCK_PULL) && mem_ack) block_buf[cnt] <= mem_rdata;
        if (state == INSTALL) begin
            tag_arr[m_set][m_way] <= m_tag;
            for (int w = 0; w < BLOCK_WORDS; w++) begin
                if (m_write && (word_off_t'(w) == m_off)) data_arr[m_set][m_way][w] <= m_wdata;
                else data_arr[m_set][m_way][w] <= block_buf[w];
            end
            resp_data <= m_write ? m_wdata : block_buf[m_off];
            resp_uuid <= m_uuid;
        end
    end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/10ps

module mem_arbiter (
    input  logic                                              CLK,
    input  logic                                              nRST,
    input  logic [cache_types_pkg::NUM_BANKS-1:0]             mem_req,
    input  logic [cache_types_pkg::NUM_BANKS-1:0]             mem_we,
    input  cache_types_pkg::addr_t [cache_types_pkg::NUM_BANKS-1:0] mem_addr,
    input  cache_types_pkg::word_t [cache_types_pkg::NUM_BANKS-1:0] mem_wdata,
    input  cache_types_pkg::word_t                            wb_rdata,
    input  logic                                              wb_ack,
    output logic [cache_types_pkg::NUM_BANKS-1:0]             mem_ack,
    output cache_types_pkg::word_t                            mem_rdata,
    output logic                                              wb_cyc,
    output logic                                              wb_stb,
    output logic                                              wb_we,
    output cache_types_pkg::addr_t                            wb_adr,
    output cache_types_pkg::word_t                            wb_wdata
);
    import cache_types_pkg::*;

    logic [$clog2(NUM_BANKS)-1:0] rr_ptr;
    logic [$clog2(NUM_BANKS)-1:0] owner;
    logic [$clog2(NUM_BANKS)-1:0] grant_idx;
    logic                         grant_any;
    logic                         grant;

    // first requester at or after the pointer
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_idx = rr_ptr;
        for (int k = NUM_BANKS - 1; k >= 0; k--) begin
            idx = (int'(rr_ptr) + k) % NUM_BANKS;
            if (mem_req[idx]) begin
                grant_any = 1'b1;
                grant_idx = idx[$clog2(NUM_BANKS)-1:0];
            end
        end
    end

    assign grant     = !wb_cyc && grant_any; // only between bus cycles
    assign mem_ack   = (wb_cyc && wb_ack) ? (NUM_BANKS'(1) << owner) : '0;
    assign mem_rdata = wb_rdata;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            rr_ptr <= '0;
        end else if (grant) begin
            wb_cyc <= 1'b1;
            wb_stb <= 1'b1;
            if (int'(grant_idx) == NUM_BANKS - 1) rr_ptr <= '0;
            else rr_ptr <= grant_idx + 1'b1;
        end else if (wb_cyc && wb_ack) begin
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
        end
    end

    always_ff @(posedge CLK) begin
        if (grant) begin // held for the whole bus cycle
            owner    <= grant_idx;
            wb_we    <= mem_we[grant_idx];
            wb_adr   <= mem_addr[grant_idx];
            wb_wdata <= mem_wdata[grant_idx];
        end
    end

endmodule

//--- verilog/banked_cache.sv
`timescale 1ns/10ps

module banked_cache (
    input  logic                                              CLK,
    input  logic                                              nRST,
    input  logic                                              req_valid,
    input  logic                                              req_write,
    input  cache_types_pkg::addr_t                            req_addr,
    input  cache_types_pkg::word_t                            req_wdata,
    input  cache_types_pkg::uuid_t                            req_uuid,
    output logic                                              req_ready,
    output logic [cache_types_pkg::NUM_BANKS-1:0]             resp_valid,
    output cache_types_pkg::word_t [cache_types_pkg::NUM_BANKS-1:0] resp_data,
    output cache_types_pkg::uuid_t [cache_types_pkg::NUM_BANKS-1:0] resp_uuid,
    output logic                                              wb_cyc,
    output logic                                              wb_stb,
    output logic                                              wb_we,
    output cache_types_pkg::addr_t                            wb_adr,
    output cache_types_pkg::word_t                            wb_wdata,
    input  cache_types_pkg::word_t                            wb_rdata,
    input  logic                                              wb_ack
);
    import cache_types_pkg::*;

    logic [NUM_BANKS-1:0]  busy;
    logic [NUM_BANKS-1:0]  bank_req_valid;
    logic                  bank_write;
    addr_t                 bank_addr;
    word_t                 bank_wdata;
    uuid_t                 bank_uuid;

    logic [NUM_BANKS-1:0]  mem_req;
    logic [NUM_BANKS-1:0]  mem_we;
    addr_t [NUM_BANKS-1:0] mem_addr;
    word_t [NUM_BANKS-1:0] mem_wdata;
    logic [NUM_BANKS-1:0]  mem_ack;
    word_t                 mem_rdata;

    bank_dispatch u_dispatch (
        .CLK            (CLK),
        .nRST           (nRST),
        .req_valid      (req_valid),
        .req_write      (req_write),
        .req_addr       (req_addr),
        .req_wdata      (req_wdata),
        .req_uuid       (req_uuid),
        .busy           (busy),
        .req_ready      (req_ready),
        .bank_req_valid (bank_req_valid),
        .bank_write     (bank_write),
        .bank_addr      (bank_addr),
        .bank_wdata     (bank_wdata),
        .bank_uuid      (bank_uuid)
    );

    for (genvar i = 0; i < NUM_BANKS; i++) begin : g_bank
        cache_bank u_bank (
            .CLK        (CLK),
            .nRST       (nRST),
            .req_valid  (bank_req_valid[i]),
            .req_write  (bank_write),
            .req_addr   (bank_addr),
            .req_wdata  (bank_wdata),
            .req_uuid   (bank_uuid),
            .mem_ack    (mem_ack[i]),
            .mem_rdata  (mem_rdata),
            .busy       (busy[i]),
            .resp_valid (resp_valid[i]),
            .resp_data  (resp_data[i]),
            .resp_uuid  (resp_uuid[i]),
            .mem_req    (mem_req[i]),
            .mem_we     (mem_we[i]),
            .mem_addr   (mem_addr[i]),
            .mem_wdata  (mem_wdata[i])
        );
    end

    mem_arbiter u_arbiter (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .wb_rdata  (wb_rdata),
        .wb_ack    (wb_ack),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_wdata  (wb_wdata)
    );

endmodule

//--- sim/wb_ram_model.sv
`timescale 1ns/10ps

module wb_ram_model #(
    parameter int          WORDS = 4096,
    parameter logic [31:0] FILL  = 32'h5a5a_0f0f,
    parameter int          SEED  = 1
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_adr,
    input  logic [31:0] wb_wdata,
    output logic [31:0] wb_rdata,
    output logic        wb_ack
);
    logic [31:0] mem [WORDS];
    logic        active;
    logic        seeded;
    int          wait_cnt;
    int          idx;

    assign idx = int'(wb_adr[2 +: $clog2(WORDS)]);

    always @(posedge CLK or negedge nRST) begin
        int delay;
        if (!nRST) begin
            wb_ack   <= 1'b0;
            active   <= 1'b0;
            seeded   <= 1'b0;
            wait_cnt <= 0;
            for (int i = 0; i < WORDS; i++) mem[i] <= 32'(i) ^ FILL; // word address xor pattern
        end else begin
            if (!seeded) begin
                void'($urandom(SEED));
                seeded <= 1'b1;
            end
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                delay = active ? wait_cnt : int'($urandom_range(3, 0));
                if (delay == 0) begin
                    wb_ack <= 1'b1;
                    active <= 1'b0;
                    if (wb_we) mem[idx] <= wb_wdata;
                    wb_rdata <= mem[idx];
                end else begin
                    active   <= 1'b1;
                    wait_cnt <= delay - 1;
                end
            end
        end
    end

endmodule

//--- sim/banked_cache_checker.sv
`timescale 1ns/10ps

module banked_cache_checker (
    input logic                                  CLK,
    input logic                                  nRST,
    input logic                                  wb_cyc,
    input logic                                  wb_stb,
    input logic                                  wb_we,
    input logic [31:0]                           wb_adr,
    input logic [31:0]                           wb_wdata,
    input logic                                  wb_ack,
    input logic [cache_types_pkg::NUM_BANKS-1:0] bank_req_valid,
    input logic [cache_types_pkg::NUM_BANKS-1:0] busy
);
    a_stb_in_cyc: assert property (@(posedge CLK) disable iff (!nRST) wb_stb |-> wb_cyc)
        else $error("wishbone stb high without cyc");

    // bus lines hold until the slave acks
    a_lines_stable: assert property (@(posedge CLK) disable iff (!nRST)
        (wb_cyc && !wb_ack) |=> (wb_cyc && wb_stb && $stable(wb_we)
                                 && $stable(wb_adr) && $stable(wb_wdata)))
        else $error("wishbone lines changed before ack");

    a_ack_with_stb: assert property (@(posedge CLK) disable iff (!nRST) wb_ack |-> wb_stb)
        else $error("wishbone ack without stb");

    a_no_issue_busy: assert property (@(posedge CLK) disable iff (!nRST)
        (bank_req_valid & busy) == '0)
        else $error("request issued to a busy bank");

endmodule

bind banked_cache banked_cache_checker u_checker (
    .CLK            (CLK),
    .nRST           (nRST),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_wdata       (wb_wdata),
    .wb_ack         (wb_ack),
    .bank_req_valid (bank_req_valid),
    .busy           (busy)
);

//--- sim/banked_cache_tb.sv
`timescale 1ns/10ps

module banked_cache_tb;
    import cache_types_pkg::*;

    localparam int          PERIOD      = 40;
    localparam int          SEED        = 50084;
    localparam int          RAM_WORDS   = 4096;
    localparam logic [31:0] FILL        = 32'h5a5a_0f0f;
    localparam int          MAX_ROWS    = 32;
    localparam int          MISS_CYCLES = 150; // eviction, refill and arbitration worst case

    logic                  CLK;
    logic                  nRST;
    logic                  req_valid;
    logic                  req_write;
    addr_t                 req_addr;
    word_t                 req_wdata;
    uuid_t                 req_uuid;
    logic                  req_ready;
    logic [NUM_BANKS-1:0]  resp_valid;
    word_t [NUM_BANKS-1:0] resp_data;
    uuid_t [NUM_BANKS-1:0] resp_uuid;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    logic                  wb_ack;
    addr_t                 wb_adr;
    word_t                 wb_wdata;
    word_t                 wb_rdata;

    // stimulus table
    logic  row_write [MAX_ROWS];
    addr_t row_addr  [MAX_ROWS];
    word_t row_wdata [MAX_ROWS];
    uuid_t row_uuid  [MAX_ROWS];
    word_t row_exp   [MAX_ROWS];
    logic  row_drain [MAX_ROWS];
    logic  row_timed [MAX_ROWS];
    int    acc_cyc   [MAX_ROWS];
    int    resp_cyc  [MAX_ROWS];
    int    stall     [MAX_ROWS];
    int    n_rows;

    // reference memory and cache model
    word_t ref_mem   [RAM_WORDS];
    logic  mdl_valid [NUM_BANKS][SETS_PER_BANK][NUM_WAYS];
    int    mdl_tag   [NUM_BANKS][SETS_PER_BANK][NUM_WAYS];
    lru_t  mdl_lru   [NUM_BANKS][SETS_PER_BANK];

    int    cyc;
    int    n_acc;
    int    n_resp;
    int    row_of_uuid [16];
    logic  pend [16];
    logic  reported;
    logic  finished_ok;
    int    idx_a;
    int    idx_b;
    int    idx_d;

    banked_cache DUT (.*);

    wb_ram_model #(.WORDS(RAM_WORDS), .FILL(FILL), .SEED(SEED)) u_ram (.*);

    initial begin
        CLK = 1'b0;
        forever #(PERIOD / 2) CLK = ~CLK;
    end

    always @(posedge CLK) cyc <= cyc + 1;

    task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error %0t: %s, got %h expected %h", $time, what, got, exp);
            reported = 1'b1;
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic stop_on(input string why);
        $display("%0t: %s", $time, why);
        reported = 1'b1;
        $display("Errors found");
        $fatal(1);
    endtask

    // predicts placement and tree lru state per set
    task automatic add_row(input logic wr, input int tag, input int set, input int bank,
                           input int off, input word_t wd, input logic drain);
        addr_t a;
        int    w;
        logic  hit;
        lru_t  l;
        a   = (addr_t'(tag) << TAG_LSB) | (addr_t'(set) << SET_LSB)
            | (addr_t'(bank) << BANK_LSB) | (addr_t'(off) << WORD_OFF_LSB);
        hit = 1'b0;
        w   = -1;
        l   = mdl_lru[bank][set];
        for (int i = 0; i < NUM_WAYS; i++) begin
            if (mdl_valid[bank][set][i] && mdl_tag[bank][set][i] == tag) begin
                hit = 1'b1;
                w   = i;
            end
        end
        for (int i = NUM_WAYS - 1; i >= 0 && !hit; i--) begin
            if (!mdl_valid[bank][set][i]) w = i;
        end
        if (w < 0) w = l[2] ? (l[0] ? 0 : 1) : (l[1] ? 2 : 3); // least recent half and way
        mdl_valid[bank][set][w] = 1'b1;
        mdl_tag[bank][set][w]   = tag;
        l[2] = (w >= 2);
        if (w >= 2) l[1] = w[0];
        else l[0] = w[0];
        mdl_lru[bank][set] = l;
        if (wr) ref_mem[a >> 2] = wd;
        row_write[n_rows] = wr;
        row_addr[n_rows]  = a;
        row_wdata[n_rows] = wd;
        row_uuid[n_rows]  = uuid_t'(n_rows % 16);
        row_exp[n_rows]   = wr ? wd : ref_mem[a >> 2];
        row_drain[n_rows] = drain;
        row_timed[n_rows] = hit && drain;
        n_rows++;
    endtask

    task automatic build_table();
        for (int i = 0; i < RAM_WORDS; i++) ref_mem[i] = 32'(i) ^ FILL;
        add_row(0, 1, 0, 0, 1, '0, 1);                     // cold read miss
        add_row(1, 2, 1, 0, 2, 32'hcafe_0001, 1);
        add_row(0, 2, 1, 0, 2, '0, 1);                     // resident now
        for (int t = 3; t <= 7; t++) add_row(1, t, 2, 1, 0, 32'h1000_0000 + t, 0);
        add_row(0, 3, 2, 1, 0, '0, 1);                     // dirty victim came back
        for (int t = 10; t <= 13; t++) add_row(0, t, 3, 0, t % 4, '0, 1);
        add_row(0, 11, 3, 0, 0, '0, 1);
        add_row(0, 14, 3, 0, 1, '0, 1);
        for (int t = 10; t <= 14; t++) add_row(0, t, 3, 0, 2, '0, 1);
        add_row(0, 20, 0, 1, 3, '0, 1);                    // make bank 1 line resident
        idx_a = n_rows;
        add_row(0, 30, 1, 0, 0, '0, 1);                    // bank 0 miss
        idx_b = n_rows;
        add_row(0, 20, 0, 1, 1, '0, 0);                    // bank 1 hit overtakes
        add_row(0, 31, 1, 0, 0, '0, 0);                    // waits in the slot
        idx_d = n_rows;
        add_row(0, 20, 0, 1, 2, '0, 0);                    // sees req_ready low
    endtask

    always @(posedge CLK) begin : collect
        int    r;
        uuid_t u;
        if (nRST) begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (resp_valid[b]) begin
                    u = resp_uuid[b];
                    if (!pend[u]) stop_on($sformatf("response with unknown uuid %0d", u));
                    r       = row_of_uuid[u];
                    pend[u] = 1'b0;
                    check_equal(b, row_addr[r][BANK_LSB], "response lane");
                    check_equal(resp_data[b], row_exp[r], $sformatf("data of row %0d", r));
                    if (row_timed[r]) check_equal(cyc - acc_cyc[r], 2, "hit latency");
                    resp_cyc[r] = cyc;
                    n_resp++;
                end
            end
        end
    end

    initial begin : watchdog
        #((16 + MAX_ROWS * MISS_CYCLES) * PERIOD);
        for (int u = 0; u < 16; u++) begin
            if (pend[u]) $display("request with uuid %0d was never answered", u);
        end
        stop_on("timeout, the cache stopped answering");
    end

    initial begin
        {req_valid, req_write, req_addr, req_wdata, req_uuid} = '0;
        nRST = 1'b0;
        {cyc, n_acc, n_resp, n_rows} = '0;
        {reported, finished_ok} = '0;
        foreach (pend[u]) pend[u] = 1'b0;
        foreach (mdl_valid[b, s, w]) mdl_valid[b][s][w] = 1'b0;
        foreach (mdl_lru[b, s]) mdl_lru[b][s] = '0;
        build_table();
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        repeat (3) begin
            @(posedge CLK);
            check_equal(req_ready, 1'b1, "req_ready after reset");
            check_equal(resp_valid, '0, "response lane idle after reset");
            check_equal({wb_cyc, wb_stb}, '0, "wishbone idle after reset");
        end
        for (int r = 0; r < n_rows; r++) begin
            if (row_drain[r]) begin
                while (n_resp != n_acc) @(posedge CLK);
            end
            @(negedge CLK);
            req_valid = 1'b1;
            req_write = row_write[r];
            req_addr  = row_addr[r];
            req_wdata = row_wdata[r];
            req_uuid  = row_uuid[r];
            stall[r]  = 0;
            @(posedge CLK);
            while (!req_ready) begin
                stall[r]++;
                @(posedge CLK);
            end
            acc_cyc[r] = cyc;
            row_of_uuid[row_uuid[r]] = r;
            pend[row_uuid[r]] = 1'b1;
            n_acc++;
            @(negedge CLK);
            req_valid = 1'b0;
        end
        while (n_resp != n_acc) @(posedge CLK);
        check_equal(resp_cyc[idx_b] < resp_cyc[idx_a], 1'b1, "bank 1 hit answered first");
        check_equal(stall[idx_d] > 0, 1'b1, "req_ready low while bank 0 slot waits");
        finished_ok = 1'b1;
        $display("No errors");
        $finish;
    end

    final begin
        if (!finished_ok && !reported) begin
            $display("run ended early, assertion failure or stop");
            $display("Errors found");
        end
    end

endmodule

//--- files.f
verilog/cache_types_pkg.sv
verilog/bank_dispatch.sv
verilog/cache_bank.sv
verilog/mem_arbiter.sv
verilog/banked_cache.sv
sim/wb_ram_model.sv
sim/banked_cache_checker.sv
sim/banked_cache_tb.sv

//--- Makefile
TOOL     = verilator
TOP      = banked_cache_tb
FILELIST = files.f
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
OBJDIR   = obj_dir
LOG      = sim.log
FAILMSG  = Errors found
PASSMSG  = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing -Wno-fatal -f $(FILELIST) --top-module $(TOP)

$(OBJDIR)/V$(TOP): $(shell cat $(FILELIST))
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	-./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAILMSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASSMSG)" $(LOG); then echo "simulation did not finish"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJDIR) $(LOG)
